/* verilog/camsync_config.svh */
// ########################################
// widths of the gpio, count and bit length fields
// register addresses of the camsync block
// reset and threshold values for period writes
// ########################################
`ifndef CAMSYNC_CONFIG_SVH
`define CAMSYNC_CONFIG_SVH

// field widths
`define CS_GPIO_W       12      // gpio lines on the connector
`define CS_CNT_W        32      // delay and period counters
`define CS_BITLEN_W     8       // output unit length minus one

// register map
`define CS_ADDR_INPUT   2'd0    // trigger source pairs
`define CS_ADDR_DELAY   2'd1    // trigger delay in pclk cycles
`define CS_ADDR_OUTPUT  2'd2    // output line pairs
`define CS_ADDR_PERIOD  2'd3    // start and period control

// longest pulse unit until software writes a bit length
`define CS_BITLEN_RESET 8'd255

// period values from here up restart on their own
`define CS_REP_MIN      32'd256

`endif

/* verilog/camsync_pkg.sv */
// ########################################
// shared types of the camsync block
// vector typedefs, config structs, fsm enums
// ########################################
`include "camsync_config.svh"

package camsync_pkg;

    typedef logic [`CS_GPIO_W-1:0]   gpio_vec_t;  // one bit per gpio line
    typedef logic [`CS_CNT_W-1:0]    count_t;     // delay or period in pclk cycles
    typedef logic [`CS_BITLEN_W-1:0] bitlen_t;    // pulse unit minus one

    // one register write, valid when en is high
    typedef struct packed {
        logic       en;
        logic [1:0] addr;
        count_t     data;
    } reg_wr_t;

    // trigger input side
    typedef struct packed {
        gpio_vec_t input_use;      // lines taking part in the match
        gpio_vec_t input_pattern;  // level expected on each used line
        logic      intern_mode;    // no line used, fire from the period generator
        count_t    input_dly;      // delay to the trigger
    } trig_cfg_t;

    // sync output side
    typedef struct packed {
        gpio_vec_t gpio_en;        // lines driven by the block
        gpio_vec_t gpio_active;    // levels while the pulse is on
        bitlen_t   bit_length;     // unit length minus one, also sets the filter
    } out_cfg_t;

    // start generator control
    typedef struct packed {
        count_t repeat_period;     // N for repetitive starts
        logic   rep_en;            // restart every N cycles
        logic   start_en;          // generator and output allowed to run
        logic   start;             // one cycle, kick off a start
    } period_cfg_t;

    typedef enum logic [1:0] {IDLE, FIRE, COUNT} pgen_state_e;
    typedef enum logic {OFF, ON} out_state_e;

endpackage

/* verilog/camsync_regs.sv */
// ########################################
// camsync register block
// address decode, pair splitting
// period write classification
// ########################################
`timescale 1ns/1ps
`include "camsync_config.svh"

module camsync_regs (
    input  logic                     pclk,
    input  logic                     trigrst,
    input  camsync_pkg::reg_wr_t     wr,
    output camsync_pkg::trig_cfg_t   trig_cfg,
    output camsync_pkg::out_cfg_t    out_cfg,
    output camsync_pkg::period_cfg_t period_cfg
);

    logic                   wr_input;   // per address write strobes
    logic                   wr_delay;
    logic                   wr_output;
    logic                   wr_period;
    logic                   is_stop;    // period write of 0
    logic                   is_single;  // period write of 1
    logic                   is_bitlen;  // 2..255, only the unit length
    logic                   is_rep;     // N and above
    camsync_pkg::gpio_vec_t use_w;      // odd bits of the input write

    // odd data bits carry enable/use, even bits the level
    function automatic camsync_pkg::gpio_vec_t pick_pairs(input camsync_pkg::count_t d,
                                                          input logic odd);
        camsync_pkg::gpio_vec_t v;
        for (int i = 0; i < `CS_GPIO_W; i++) begin
            v[i] = d[2*i + odd];
        end
        return v;
    endfunction

    assign wr_input  = wr.en && (wr.addr == `CS_ADDR_INPUT);
    assign wr_delay  = wr.en && (wr.addr == `CS_ADDR_DELAY);
    assign wr_output = wr.en && (wr.addr == `CS_ADDR_OUTPUT);
    assign wr_period = wr.en && (wr.addr == `CS_ADDR_PERIOD);

    assign is_stop   = (wr.data == '0);
    assign is_single = (wr.data == 32'd1);
    assign is_rep    = (wr.data >= `CS_REP_MIN);
    assign is_bitlen = !is_stop && !is_single && !is_rep;

    assign use_w = pick_pairs(wr.data, 1'b1);

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            trig_cfg   <= '0;
            trig_cfg.intern_mode <= 1'b1;     // empty use mask
            out_cfg    <= '0;
            out_cfg.bit_length   <= `CS_BITLEN_RESET;
            period_cfg <= '0;
        end else begin
            period_cfg.start <= wr_period && (is_single || is_rep);  // single cycle
            if (wr_input) begin
                trig_cfg.input_use     <= use_w;
                trig_cfg.input_pattern <= pick_pairs(wr.data, 1'b0);
                trig_cfg.intern_mode   <= (use_w == '0);
            end
            if (wr_delay)
                trig_cfg.input_dly <= wr.data;
            if (wr_output) begin
                out_cfg.gpio_en     <= pick_pairs(wr.data, 1'b1);
                out_cfg.gpio_active <= pick_pairs(wr.data, 1'b0);
            end
            if (wr_period) begin
                if (is_bitlen) begin
                    out_cfg.bit_length <= wr.data[`CS_BITLEN_W-1:0];  // nothing starts
                end else begin
                    period_cfg.repeat_period <= wr.data;
                    period_cfg.rep_en        <= is_rep;
                    period_cfg.start_en      <= !is_stop;   // 0 stops everything
                end
            end
        end
    end

endmodule

/* verilog/trig_input_filter.sv */
// ########################################
// external trigger detection
// pattern match, de-glitch counter
// rising edge of the filtered level
// ########################################
`timescale 1ns/1ps
`include "camsync_config.svh"

module trig_input_filter (
    input  logic                   pclk,
    input  logic                   trigrst,
    input  logic                   triggered_mode,
    input  camsync_pkg::trig_cfg_t trig_cfg,
    input  camsync_pkg::bitlen_t   bit_length,
    input  camsync_pkg::gpio_vec_t gpio_in,
    output logic                   ext_edge
);

    logic                     match_q;    // all used lines at their pattern level
    logic                     match_d;    // previous match, for change detect
    logic [`CS_BITLEN_W-2:0]  flt_cnt;    // msb set once the match held long enough
    logic                     filt_q;     // accepted level
    logic                     filt_d;
    logic                     force_low;

    // internal source or free running sensor ignore the lines
    assign force_low = trig_cfg.intern_mode || !triggered_mode;

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            match_q <= 1'b0;
            match_d <= 1'b0;
            flt_cnt <= '0;
            filt_q  <= 1'b0;
            filt_d  <= 1'b0;
        end else begin
            match_q <= (((gpio_in ^ trig_cfg.input_pattern) & trig_cfg.input_use) == '0);
            match_d <= match_q;

            // restart on every change, count (bit_length >> 2) + 1 stable cycles
            if (!triggered_mode || (match_q != match_d))
                flt_cnt <= {1'b0, bit_length[`CS_BITLEN_W-1:2]};
            else if (!flt_cnt[`CS_BITLEN_W-2])
                flt_cnt <= flt_cnt - 1'b1;

            if (force_low)
                filt_q <= 1'b0;
            else if (flt_cnt[`CS_BITLEN_W-2])
                filt_q <= match_d;            // level held long enough
            filt_d <= filt_q;
        end
    end

    assign ext_edge = filt_q && !filt_d;   // one cycle per accepted match

endmodule

/* verilog/trig_period_gen.sv */
// ########################################
// start pulse generator
// single shot or repetitive starts
// restart period exactly N cycles
// ########################################
`timescale 1ns/1ps

module trig_period_gen (
    input  logic                     pclk,
    input  logic                     trigrst,
    input  camsync_pkg::period_cfg_t period_cfg,
    output logic                     start_pulse
);

    camsync_pkg::pgen_state_e state;
    camsync_pkg::pgen_state_e state_nxt;
    camsync_pkg::count_t      rest_cnt;   // COUNT cycles left before the next FIRE

    always_comb begin
        state_nxt = state;
        case (state)
            camsync_pkg::IDLE: begin
                if (period_cfg.start)
                    state_nxt = camsync_pkg::FIRE;
            end
            camsync_pkg::FIRE: begin
                if (period_cfg.start)
                    state_nxt = camsync_pkg::FIRE;            // fresh start right away
                else if (period_cfg.rep_en && period_cfg.start_en)
                    state_nxt = camsync_pkg::COUNT;
                else
                    state_nxt = camsync_pkg::IDLE;            // single shot done
            end
            camsync_pkg::COUNT: begin
                if (!period_cfg.start_en)
                    state_nxt = camsync_pkg::IDLE;            // stopped by a write of 0
                else if (period_cfg.start || (rest_cnt == '0))
                    state_nxt = camsync_pkg::FIRE;
            end
            default: state_nxt = camsync_pkg::IDLE;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            state    <= camsync_pkg::IDLE;
            rest_cnt <= '0;
        end else begin
            state <= state_nxt;
            // FIRE plus N-1 COUNT cycles gives N between pulses
            if ((state_nxt == camsync_pkg::COUNT) && (state != camsync_pkg::COUNT))
                rest_cnt <= period_cfg.repeat_period - 2;
            else if (state == camsync_pkg::COUNT)
                rest_cnt <= rest_cnt - 1'b1;
        end
    end

    assign start_pulse = (state == camsync_pkg::FIRE);   // one cycle per start

endmodule

/* verilog/trig_delay_fire.sv */
// ########################################
// trigger delay and sensor trigger
// delay counter, trigger1 select
// toggling trigger and overdue flag
// ########################################
`timescale 1ns/1ps

module trig_delay_fire (
    input  logic                   pclk,
    input  logic                   trigrst,
    input  logic                   frame_start,
    input  logic                   triggered_mode,
    input  camsync_pkg::trig_cfg_t trig_cfg,
    input  logic                   start_pulse,
    input  logic                   ext_edge,
    output logic                   delay_done,
    output logic                   trigger1,
    output logic                   trigger,
    output logic                   overdue
);

    logic                dly_run;    // delay counter busy
    logic                dly_src;    // event that loads the counter
    camsync_pkg::count_t dly_cnt;
    camsync_pkg::count_t dly_load;

    assign dly_src  = trig_cfg.intern_mode ? start_pulse : (triggered_mode && ext_edge);
    assign dly_load = (trig_cfg.input_dly == '0) ? 32'd1 : trig_cfg.input_dly;  // 0 acts as 1

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            dly_run    <= 1'b0;
            dly_cnt    <= '0;
            delay_done <= 1'b0;
        end else begin
            delay_done <= 1'b0;
            if (!dly_run) begin
                if (dly_src) begin                 // later edges wait for the count to end
                    dly_run <= 1'b1;
                    dly_cnt <= dly_load;
                end
            end else if (dly_cnt == 32'd1) begin
                dly_run    <= 1'b0;
                delay_done <= 1'b1;                // D+1 cycles after the source
            end else begin
                dly_cnt <= dly_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            trigger1 <= 1'b0;
        end else begin
            // internal mode skips the delay, it moves to the output instead
            trigger1 <= trig_cfg.intern_mode ? start_pulse : delay_done;
        end
    end

    // toggle so a missed frame start can not lock the sensor up
    always_ff @(posedge pclk) begin
        if (trigrst || frame_start) begin
            trigger <= 1'b0;
            overdue <= 1'b0;
        end else begin
            trigger <= trigger ^ trigger1;
            if (trigger1)
                overdue <= trigger;                // still high means no frame started
        end
    end

endmodule

/* verilog/sync_out_drv.sv */
// ########################################
// gpio sync output
// pulse of four units, OFF/ON fsm
// active or inverse line levels
// ########################################
`timescale 1ns/1ps

module sync_out_drv (
    input  logic                   pclk,
    input  logic                   trigrst,
    input  camsync_pkg::out_cfg_t  out_cfg,
    input  logic                   intern_mode,
    input  logic                   start_en,
    input  logic                   start_pulse,
    input  logic                   delay_done,
    output camsync_pkg::gpio_vec_t gpio_out,
    output camsync_pkg::gpio_vec_t gpio_out_en
);

    camsync_pkg::out_state_e state;
    camsync_pkg::bitlen_t    bit_cnt;    // cycles left in the current unit
    logic [1:0]              unit_cnt;   // units left after the current one
    logic                    go;

    // internal mode delays the output, external mode the trigger
    assign go = intern_mode ? delay_done : start_pulse;

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            state    <= camsync_pkg::OFF;
            bit_cnt  <= '0;
            unit_cnt <= '0;
        end else begin
            case (state)
                camsync_pkg::OFF: begin
                    bit_cnt  <= out_cfg.bit_length;
                    unit_cnt <= 2'd3;
                    if (go && start_en)
                        state <= camsync_pkg::ON;
                end
                camsync_pkg::ON: begin
                    if (!start_en) begin
                        state <= camsync_pkg::OFF;      // stop write cuts the pulse
                    end else if (bit_cnt == '0) begin
                        bit_cnt <= out_cfg.bit_length;
                        if (unit_cnt == 2'd0)
                            state <= camsync_pkg::OFF;  // 4 x (bit_length + 1) done
                        else
                            unit_cnt <= unit_cnt - 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default: state <= camsync_pkg::OFF;
            endcase
        end
    end

    assign gpio_out    = (state == camsync_pkg::ON) ? out_cfg.gpio_active : ~out_cfg.gpio_active;
    assign gpio_out_en = out_cfg.gpio_en;

endmodule

/* verilog/camsync_top.sv */
// ########################################
// camsync top level
// register block, input filter, period
// generator, delay and output driver
// ########################################
`timescale 1ns/1ps

module camsync_top (
    input  logic                   pclk,
    input  logic                   trigrst,
    input  camsync_pkg::reg_wr_t   wr,
    input  logic                   triggered_mode,   // 0 means free running sensor
    input  logic                   frame_start,
    input  camsync_pkg::gpio_vec_t gpio_in,
    output camsync_pkg::gpio_vec_t gpio_out,
    output camsync_pkg::gpio_vec_t gpio_out_en,
    output logic                   trigger1,
    output logic                   trigger,
    output logic                   overdue
);

    camsync_pkg::trig_cfg_t   trig_cfg;
    camsync_pkg::out_cfg_t    out_cfg;
    camsync_pkg::period_cfg_t period_cfg;
    logic                     start_pulse;
    logic                     ext_edge;
    logic                     delay_done;

    camsync_regs u_regs (
        .pclk       (pclk),
        .trigrst    (trigrst),
        .wr         (wr),
        .trig_cfg   (trig_cfg),
        .out_cfg    (out_cfg),
        .period_cfg (period_cfg)
    );

    trig_input_filter u_filter (
        .pclk           (pclk),
        .trigrst        (trigrst),
        .triggered_mode (triggered_mode),
        .trig_cfg       (trig_cfg),
        .bit_length     (out_cfg.bit_length),
        .gpio_in        (gpio_in),
        .ext_edge       (ext_edge)
    );

    trig_period_gen u_pgen (
        .pclk        (pclk),
        .trigrst     (trigrst),
        .period_cfg  (period_cfg),
        .start_pulse (start_pulse)
    );

    trig_delay_fire u_fire (
        .pclk           (pclk),
        .trigrst        (trigrst),
        .frame_start    (frame_start),
        .triggered_mode (triggered_mode),
        .trig_cfg       (trig_cfg),
        .start_pulse    (start_pulse),
        .ext_edge       (ext_edge),
        .delay_done     (delay_done),
        .trigger1       (trigger1),
        .trigger        (trigger),
        .overdue        (overdue)
    );

    sync_out_drv u_out (
        .pclk        (pclk),
        .trigrst     (trigrst),
        .out_cfg     (out_cfg),
        .intern_mode (trig_cfg.intern_mode),
        .start_en    (period_cfg.start_en),
        .start_pulse (start_pulse),
        .delay_done  (delay_done),
        .gpio_out    (gpio_out),
        .gpio_out_en (gpio_out_en)
    );

endmodule

/* dv/camsync_tb.sv */
// ########################################
// camsync testbench
// register writes, lfsr, reference functions
// gpio and sensor trigger checker
// ########################################
`timescale 1ns/1ps
`include "camsync_config.svh"

module camsync_tb;

    logic                   pclk;
    logic                   trigrst;
    camsync_pkg::reg_wr_t   wr;
    logic                   triggered_mode;
    logic                   frame_start;
    camsync_pkg::gpio_vec_t gpio_in;
    camsync_pkg::gpio_vec_t gpio_out;
    camsync_pkg::gpio_vec_t gpio_out_en;
    logic                   trigger1;
    logic                   trigger;
    logic                   overdue;

    logic [31:0]            lfsr;       // fibonacci lfsr state
    camsync_pkg::count_t    out_word;   // last word written to the output register
    bit                     checking;   // monitor armed after reset
    bit                     exp_trig;   // model of trigger
    bit                     exp_over;   // model of overdue
    int                     errors;
    int                     tests;
    int                     failed;
    int                     err_mark;   // error count at test start

    camsync_top u_dut (
        .pclk           (pclk),
        .trigrst        (trigrst),
        .wr             (wr),
        .triggered_mode (triggered_mode),
        .frame_start    (frame_start),
        .gpio_in        (gpio_in),
        .gpio_out       (gpio_out),
        .gpio_out_en    (gpio_out_en),
        .trigger1       (trigger1),
        .trigger        (trigger),
        .overdue        (overdue)
    );

    always #4 pclk = ~pclk;   // 8 ns period

    // taps x^32 + x^22 + x^2 + x + 1
    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // odd bit of each pair is use/enable, even bit the level
    function automatic camsync_pkg::gpio_vec_t split_pairs(input camsync_pkg::count_t w,
                                                           input bit odd);
        camsync_pkg::gpio_vec_t v;
        for (int i = 0; i < `CS_GPIO_W; i++)
            v[i] = odd ? w[2*i+1] : w[2*i];
        return v;
    endfunction

    function automatic camsync_pkg::count_t join_pairs(input camsync_pkg::gpio_vec_t odd_v,
                                                       input camsync_pkg::gpio_vec_t even_v);
        camsync_pkg::count_t w;
        w = '0;
        for (int i = 0; i < `CS_GPIO_W; i++) begin
            w[2*i+1] = odd_v[i];
            w[2*i]   = even_v[i];
        end
        return w;
    endfunction

    function automatic int eff_delay(input int d);
        return (d == 0) ? 1 : d;   // D = 0 behaves like 1
    endfunction

    function automatic int pulse_len(input int bl);
        return 4 * (bl + 1);
    endfunction

    function automatic int filt_len(input int bl);
        return (bl >> 2) + 1;
    endfunction

    // next {trigger, overdue} from the current state and inputs
    function automatic logic [1:0] next_sensor(input bit t, input bit o, input logic t1,
                                               input logic fs, input logic rst);
        if (rst || fs)
            return 2'b00;
        return {t ^ t1, t1 ? t : o};
    endfunction

    // compare outputs at the falling edge
    always @(negedge pclk) begin
        if (checking) begin
            assert (trigger === exp_trig && overdue === exp_over) else begin
                $display("Fail %0t: trigger/overdue %b%b, expected %b%b", $time,
                         trigger, overdue, exp_trig, exp_over);
                errors++;
            end
            assert (gpio_out_en === split_pairs(out_word, 1'b1)) else begin
                $display("Fail %0t: gpio_out_en %h does not match register", $time, gpio_out_en);
                errors++;
            end
            assert (gpio_out === split_pairs(out_word, 1'b0) ||
                    gpio_out === ~split_pairs(out_word, 1'b0)) else begin
                $display("Fail %0t: gpio_out %h is neither active nor inverse", $time, gpio_out);
                errors++;
            end
        end
        {exp_trig, exp_over} = next_sensor(exp_trig, exp_over, trigger1, frame_start, trigrst);
    end

    task automatic reg_write(input logic [1:0] addr, input camsync_pkg::count_t data);
        @(posedge pclk);
        wr.en   <= 1'b1;
        wr.addr <= addr;
        wr.data <= data;
        @(posedge pclk);        // write sampled here
        wr.en   <= 1'b0;
        if (addr == `CS_ADDR_OUTPUT)
            out_word = data;
    endtask

    // cycles to the next trigger1 in falling edges
    task automatic wait_rise(input int limit, output int n, output bit seen);
        seen = 1'b0;
        for (n = 1; n <= limit; n++) begin
            @(negedge pclk);
            if (trigger1) begin
                seen = 1'b1;
                break;
            end
        end
    endtask

    task automatic expect_rise(input int limit, output int n);
        bit seen;
        wait_rise(limit, n, seen);
        if (!seen) begin
            $display("timeout: trigger1 did not rise within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic expect_none(input int limit);
        int  n;
        bit  seen;
        wait_rise(limit, n, seen);
        assert (!seen) else begin
            $display("Fail %0t: unexpected trigger1", $time);
            errors++;
        end
    endtask

    // trigger1 time, pulse start and pulse length in one pass
    task automatic watch(input int limit, output int t1_at, output int on_at, output int len);
        int n;
        bit on;
        t1_at = 0;
        on_at = 0;
        len   = 0;
        for (n = 1; n <= limit; n++) begin
            @(negedge pclk);
            on = (gpio_out === split_pairs(out_word, 1'b0));
            if (trigger1 && t1_at == 0)
                t1_at = n;
            if (on && on_at == 0)
                on_at = n;
            if (on)
                len++;
            if (on_at != 0 && !on && t1_at != 0)
                break;          // pulse over
        end
    endtask

    task automatic check_shot(input int t1_at, input int on_at, input int len,
                              input int dx, input int bl);
        if (t1_at == 0 || on_at == 0) begin
            $display("timeout: single shot gave no trigger1 or no output pulse");
            errors++;
        end else begin
            assert (t1_at == 3) else begin
                $display("Fail %0t: trigger1 %0d cycles after write, expected 3", $time, t1_at);
                errors++;
            end
            assert (on_at == dx + 4) else begin
                $display("Fail %0t: pulse at %0d, expected %0d", $time, on_at, dx + 4);
                errors++;
            end
            assert (len == pulse_len(bl)) else begin
                $display("Fail %0t: pulse %0d long, expected %0d", $time, len, pulse_len(bl));
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != err_mark)
            failed++;
        $display("test %0d %s: %s", tests, name, (errors != err_mark) ? "FAILED" : "ok");
        err_mark = errors;
    endtask

    initial begin
        int                     n;
        int                     t1_at;
        int                     on_at;
        int                     len;
        int                     dx;
        int                     bl;
        int                     f;
        camsync_pkg::count_t    d;
        camsync_pkg::count_t    nper;
        camsync_pkg::gpio_vec_t use_m;
        camsync_pkg::gpio_vec_t pat;
        camsync_pkg::gpio_vec_t match;
        camsync_pkg::gpio_vec_t miss_all;
        lfsr           = 32'h91e5_a9a5;
        pclk           = 1'b0;
        trigrst        = 1'b1;
        wr             = '0;
        triggered_mode = 1'b0;
        frame_start    = 1'b0;
        gpio_in        = '0;
        out_word       = '0;
        repeat (10) @(posedge pclk);
        trigrst  <= 1'b0;
        checking  = 1'b1;

        // 1: internal single shot at reset bit length
        d  = rand_bits(4);
        dx = eff_delay(d);
        reg_write(`CS_ADDR_OUTPUT, rand_bits(24));
        reg_write(`CS_ADDR_DELAY, d);
        reg_write(`CS_ADDR_PERIOD, 32'd1);
        watch(dx + 4 + pulse_len(`CS_BITLEN_RESET) + 16, t1_at, on_at, len);
        check_shot(t1_at, on_at, len, dx, `CS_BITLEN_RESET);
        end_test("internal single shot");

        // 2: bit length write, then a shorter shot
        bl = 2 + rand_bits(8) % 254;
        reg_write(`CS_ADDR_PERIOD, bl);
        watch(40, t1_at, on_at, len);
        assert (t1_at == 0 && on_at == 0) else begin
            $display("Fail %0t: bit length write started a pulse", $time);
            errors++;
        end
        reg_write(`CS_ADDR_PERIOD, 32'd1);
        watch(dx + 4 + pulse_len(bl) + 16, t1_at, on_at, len);
        check_shot(t1_at, on_at, len, dx, bl);
        end_test("bit length");

        // 3: repetitive starts, exact period, then stop
        nper = `CS_REP_MIN + rand_bits(8);
        reg_write(`CS_ADDR_PERIOD, nper);
        expect_rise(8, n);
        assert (n == 3) else begin
            $display("Fail %0t: first repeat at %0d, expected 3", $time, n);
            errors++;
        end
        repeat (2) begin
            expect_rise(nper + 8, n);
            assert (n == nper) else begin
                $display("Fail %0t: period %0d, expected %0d", $time, n, nper);
                errors++;
            end
        end
        reg_write(`CS_ADDR_PERIOD, 32'd0);
        expect_none(nper + 16);
        end_test("repetitive");

        // 4: external trigger, match, glitch, used line mismatch
        bl = 8 + rand_bits(8) % 248;    // F of at least 3 leaves room for a glitch
        f  = filt_len(bl);
        use_m = rand_bits(12);
        if ((use_m & (use_m - 1'b1)) == '0)
            use_m = use_m | 12'h003;    // two used lines so one wrong line is a partial match
        pat      = rand_bits(12);
        match    = (pat & use_m) | (rand_bits(12) & ~use_m);   // unused lines are don't care
        miss_all = match ^ use_m;
        @(posedge pclk);
        triggered_mode <= 1'b1;
        gpio_in        <= miss_all;
        reg_write(`CS_ADDR_PERIOD, bl);
        reg_write(`CS_ADDR_INPUT, join_pairs(use_m, pat));
        repeat (f + 12) @(posedge pclk);
        gpio_in <= match;
        expect_rise(dx + f + 12, n);
        assert (n >= dx + f + 2 && n <= dx + f + 6) else begin
            $display("Fail %0t: latency %0d outside %0d..%0d", $time, n, dx + f + 2, dx + f + 6);
            errors++;
        end
        expect_none(dx + f + 20);       // held match fires once
        @(posedge pclk);
        gpio_in <= miss_all;
        repeat (f + 12) @(posedge pclk);
        gpio_in <= match;
        repeat (f - 1) @(posedge pclk);
        gpio_in <= miss_all;            // glitch of F-1 cycles
        expect_none(dx + f + 20);
        @(posedge pclk);
        gpio_in <= match ^ (use_m & (~use_m + 1'b1));   // lowest used line wrong
        expect_none(dx + f + 20);
        end_test("external trigger");

        // 5: free running sensor ignores the lines
        @(posedge pclk);
        gpio_in        <= miss_all;
        triggered_mode <= 1'b0;
        repeat (f + 12) @(posedge pclk);
        gpio_in <= match;
        expect_none(dx + f + 20);
        end_test("free running");

        // 6: trigger toggle and overdue, cleared by frame_start
        reg_write(`CS_ADDR_INPUT, 32'd0);   // back to internal mode
        @(posedge pclk);
        frame_start <= 1'b1;
        @(posedge pclk);
        frame_start <= 1'b0;
        repeat (3) begin
            reg_write(`CS_ADDR_PERIOD, 32'd1);
            expect_rise(8, n);
            @(negedge pclk);                // toggle lands one cycle later
        end
        assert (trigger === 1'b1 && overdue === 1'b0) else begin
            $display("Fail %0t: after three shots %b%b, expected 10", $time, trigger, overdue);
            errors++;
        end
        @(posedge pclk);
        frame_start <= 1'b1;
        @(posedge pclk);
        frame_start <= 1'b0;
        @(negedge pclk);
        assert (trigger === 1'b0 && overdue === 1'b0) else begin
            $display("Fail %0t: frame_start did not clear trigger and overdue", $time);
            errors++;
        end
        end_test("sensor trigger");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/camsync_pkg.sv
verilog/camsync_regs.sv
verilog/trig_input_filter.sv
verilog/trig_period_gen.sv
verilog/trig_delay_fire.sv
verilog/sync_out_drv.sv
verilog/camsync_top.sv
dv/camsync_tb.sv
